// ==== tb.f ====
pmp_pkg.sv
pmp_wr_if.sv
pmp_csr_ctrl.sv
pmp_regfile.sv
pmp_checker.sv
pmp_top.sv
pmp_assertions.sv
tb_pmp.sv

// ==== tb_pmp.sv ====
`timescale 1ns/1ps

module tb_pmp;

  // Long enough for every test with a wide margin
  localparam int TIMEOUT_CYCLES = 3000;

  logic        clk;
  logic        rst_n_i;
  logic        csr_we_i;
  logic [11:0] csr_addr_i;
  logic [31:0] csr_wdata_i;
  logic [31:0] csr_rdata_o;
  logic        req_valid_i;
  logic [33:0] req_addr_i;
  logic [1:0]  req_type_i;
  logic [1:0]  priv_lvl_i;
  logic        rsp_valid_o;
  logic        rsp_err_o;

  // Shadow copy of the CSRs, pmpaddr kept as the 32-bit CSR word
  pmp_pkg::pmp_cfg_t     sh_cfg  [4];
  logic [31:0]           sh_addr [4];
  pmp_pkg::pmp_mseccfg_t sh_sec;

  bit    exp_q [$];
  int    seed = 74;
  int    cycle_cnt = 0;
  int    pass_cnt = 0;
  int    mismatch_cnt = 0;
  int    other_err_cnt = 0;
  int    test_start_err;
  string test_name;

  pmp_top u_dut (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .csr_we_i    (csr_we_i),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .req_valid_i (req_valid_i),
    .req_addr_i  (req_addr_i),
    .req_type_i  (req_type_i),
    .priv_lvl_i  (priv_lvl_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_err_o   (rsp_err_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------
  // Reference model
  // ------------------------------------------------

  // Region hit test from the pmpaddr rules, byte address in
  function automatic bit region_match(int i, logic [33:0] a);
    logic [63:0] lo;
    logic [63:0] hi;
    logic [63:0] size;
    logic [31:0] p;
    int          k;
    p = sh_addr[i];
    region_match = 1'b0;
    case (sh_cfg[i].mode)
      pmp_pkg::PMP_MODE_TOR: begin
        lo = 64'd0;
        if (i > 0) lo = {30'd0, sh_addr[i-1], 2'b00};
        hi = {30'd0, p, 2'b00};
        region_match = ({30'd0, a} >= lo) && ({30'd0, a} < hi);
      end
      pmp_pkg::PMP_MODE_NA4: region_match = (a[33:2] == p);
      pmp_pkg::PMP_MODE_NAPOT: begin
        // k trailing ones give a region of 2^(k+3) bytes
        k = 0;
        while (k < 32 && p[k]) k++;
        size = 64'd8 << k;
        region_match = (({30'd0, a} & ~(size - 1)) == ({30'd0, p, 2'b00} & ~(size - 1)));
      end
      default: region_match = 1'b0;
    endcase
  endfunction

  // Effective {R,W,X} per privilege, then pick the bit for the access type
  function automatic bit perm_ok(pmp_pkg::pmp_cfg_t c, logic [1:0] t, logic [1:0] p,
                                 bit mml);
    logic [2:0] rwx;
    logic [2:0] m_rwx;
    logic [2:0] su_rwx;
    rwx = {c.read, c.write, c.exec};
    if (!mml) begin
      m_rwx  = c.lock ? rwx : 3'b111;
      su_rwx = rwx;
    end else if (!c.read && c.write) begin
      // Shared encodings of Smepmp
      case ({c.lock, c.exec})
        2'b00:   {m_rwx, su_rwx} = 6'b110_100;
        2'b01:   {m_rwx, su_rwx} = 6'b110_110;
        2'b10:   {m_rwx, su_rwx} = 6'b001_001;
        default: {m_rwx, su_rwx} = 6'b101_001;
      endcase
    end else if (c.lock && rwx == 3'b111) begin
      m_rwx  = 3'b100;
      su_rwx = 3'b100;
    end else if (c.lock) begin
      m_rwx  = rwx;
      su_rwx = 3'b000;
    end else begin
      m_rwx  = 3'b000;
      su_rwx = rwx;
    end
    // EXEC is bit 0, WRITE bit 1, READ bit 2
    perm_ok = (p == 2'd3) ? m_rwx[t] : su_rwx[t];
  endfunction

  function automatic bit ref_fault(logic [33:0] a, logic [1:0] t, logic [1:0] p);
    bit found;
    found = 1'b0;
    // No match: only M without MMWP gets through
    ref_fault = sh_sec.mmwp || (p != 2'd3);
    for (int i = 0; i < 4; i++) begin
      if (!found && region_match(i, a)) begin
        found = 1'b1;
        ref_fault = !perm_ok(sh_cfg[i], t, p, sh_sec.mml);
      end
    end
  endfunction

  // Apply one CSR write to the shadow copy with the lock rules
  function automatic void shadow_write(logic [11:0] a, logic [31:0] d);
    bit any_lock;
    bit frozen;
    any_lock = 1'b0;
    for (int i = 0; i < 4; i++) any_lock = any_lock || sh_cfg[i].lock;
    if (a == pmp_pkg::CSR_ADDR_PMPCFG0) begin
      for (int i = 0; i < 4; i++) begin
        if (!sh_cfg[i].lock || sh_sec.rlb) sh_cfg[i] = d[8*i +: 8];
      end
    end
    for (int i = 0; i < 4; i++) begin
      if (a == pmp_pkg::CSR_ADDR_PMPADDR0 + i) begin
        frozen = sh_cfg[i].lock;
        if (i < 3) begin
          frozen = frozen || (sh_cfg[i+1].lock && sh_cfg[i+1].mode == pmp_pkg::PMP_MODE_TOR);
        end
        if (!frozen || sh_sec.rlb) sh_addr[i] = d;
      end
    end
    if (a == pmp_pkg::CSR_ADDR_MSECCFG) begin
      if (sh_sec.rlb || !any_lock) sh_sec.rlb = d[2];
      sh_sec.mmwp = sh_sec.mmwp || d[1];
      sh_sec.mml  = sh_sec.mml || d[0];
    end
  endfunction

  function automatic logic [31:0] shadow_rdata(logic [11:0] a);
    shadow_rdata = 32'd0;
    if (a == pmp_pkg::CSR_ADDR_PMPCFG0) begin
      shadow_rdata = {sh_cfg[3], sh_cfg[2], sh_cfg[1], sh_cfg[0]};
    end
    if (a == pmp_pkg::CSR_ADDR_MSECCFG) shadow_rdata = {29'd0, sh_sec};
    for (int i = 0; i < 4; i++) begin
      if (a == pmp_pkg::CSR_ADDR_PMPADDR0 + i) shadow_rdata = sh_addr[i];
    end
  endfunction

  // ------------------------------------------------
  // Checking
  // ------------------------------------------------

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      mismatch_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  // Every failure so far, assertions included
  function automatic int error_count();
    error_count = mismatch_cnt + other_err_cnt + int'(u_dut.u_assertions.fail_cnt);
  endfunction

  // Each response pairs with the oldest queued expectation
  always @(negedge clk) begin
    if (rsp_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("ERROR: response arrived with no request outstanding at %0t", $time);
        other_err_cnt++;
      end else begin
        check_value("rsp_err_o", rsp_err_o, exp_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("ERROR: timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // ------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------

  task automatic do_reset();
    @(negedge clk);
    rst_n_i     = 1'b0;
    csr_we_i    = 1'b0;
    req_valid_i = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    for (int i = 0; i < 4; i++) begin
      sh_cfg[i]  = '0;
      sh_addr[i] = '0;
    end
    sh_sec = '0;
  endtask

  task automatic csr_write(input logic [11:0] a, input logic [31:0] d);
    @(negedge clk);
    req_valid_i = 1'b0;
    csr_we_i    = 1'b1;
    csr_addr_i  = a;
    csr_wdata_i = d;
    shadow_write(a, d);
    @(negedge clk);
    csr_we_i = 1'b0;
  endtask

  // Read data is combinational, sampled mid-cycle
  task automatic csr_read(input logic [11:0] a, input string name);
    @(negedge clk);
    req_valid_i = 1'b0;
    csr_addr_i  = a;
    #1;
    check_value(name, csr_rdata_o, shadow_rdata(a));
  endtask

  task automatic send_req(input logic [33:0] a, input logic [1:0] t, input logic [1:0] p);
    @(negedge clk);
    req_valid_i = 1'b1;
    req_addr_i  = a;
    req_type_i  = t;
    priv_lvl_i  = p;
    exp_q.push_back(ref_fault(a, t, p));
  endtask

  task automatic finish_requests();
    @(negedge clk);
    req_valid_i = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  // Mostly near region edges, sometimes anywhere
  function automatic logic [33:0] pick_addr();
    logic [33:0] base;
    int          off;
    off = int'($unsigned($random(seed)) % 32) - 16;
    case ($unsigned($random(seed)) % 8)
      0: base = 34'h1000;
      1: base = 34'h2000;
      2: base = 34'h2800;
      3: base = 34'h2804;
      4: base = 34'h4000;
      5: base = 34'h0;
      default: return 34'({$random(seed), $random(seed)});
    endcase
    pick_addr = base + 34'(off);
  endfunction

  function automatic logic [1:0] pick_priv();
    case ($unsigned($random(seed)) % 3)
      0: pick_priv = 2'd0;
      1: pick_priv = 2'd1;
      default: pick_priv = 2'd3;
    endcase
  endfunction

  function automatic logic [1:0] pick_type();
    pick_type = 2'($unsigned($random(seed)) % 3);
  endfunction

  task automatic read_all();
    csr_read(pmp_pkg::CSR_ADDR_PMPCFG0, "pmpcfg0");
    csr_read(pmp_pkg::CSR_ADDR_PMPADDR0, "pmpaddr0");
    csr_read(pmp_pkg::CSR_ADDR_PMPADDR0 + 12'd1, "pmpaddr1");
    csr_read(pmp_pkg::CSR_ADDR_PMPADDR0 + 12'd2, "pmpaddr2");
    csr_read(pmp_pkg::CSR_ADDR_PMPADDR0 + 12'd3, "pmpaddr3");
    csr_read(pmp_pkg::CSR_ADDR_MSECCFG, "mseccfg");
  endtask

  task automatic test_begin(input string name);
    test_name      = name;
    test_start_err = error_count();
  endtask

  task automatic test_end();
    $display("%s: %0d errors", test_name, error_count() - test_start_err);
  endtask

  // ------------------------------------------------
  // Tests
  // ------------------------------------------------

  initial begin
    rst_n_i     = 1'b0;
    csr_we_i    = 1'b0;
    csr_addr_i  = '0;
    csr_wdata_i = '0;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    req_type_i  = '0;
    priv_lvl_i  = '0;
    do_reset();

    // Everything OFF, only M gets through
    test_begin("reset defaults");
    read_all();
    for (int j = 0; j < 12; j++) begin
      send_req(pick_addr(), pick_type(), (j % 3 == 2) ? 2'd3 : 2'(j % 3));
    end
    finish_requests();
    test_end();

    // OFF, TOR 0x1000-0x1FFF, NA4 0x2800 inside NAPOT 0x2000-0x3FFF
    test_begin("matching modes");
    csr_write(pmp_pkg::CSR_ADDR_PMPADDR0, 32'h400);
    csr_write(pmp_pkg::CSR_ADDR_PMPADDR0 + 12'd1, 32'h800);
    csr_write(pmp_pkg::CSR_ADDR_PMPADDR0 + 12'd2, 32'hA00);
    csr_write(pmp_pkg::CSR_ADDR_PMPADDR0 + 12'd3, 32'hBFF);
    csr_write(pmp_pkg::CSR_ADDR_PMPCFG0, 32'h1913_0D07);
    read_all();
    for (int j = 0; j < 200; j++) send_req(pick_addr(), pick_type(), pick_priv());
    finish_requests();
    test_end();

    // Region 1 locked TOR also freezes pmpaddr0
    test_begin("lock rules");
    csr_write(pmp_pkg::CSR_ADDR_PMPCFG0, 32'h1913_8D07);
    csr_write(pmp_pkg::CSR_ADDR_PMPCFG0, 32'h1913_0F07);
    csr_write(pmp_pkg::CSR_ADDR_PMPADDR0 + 12'd1, 32'h123);
    csr_write(pmp_pkg::CSR_ADDR_PMPADDR0, 32'h456);
    csr_write(pmp_pkg::CSR_ADDR_PMPADDR0 + 12'd2, 32'hA01);
    read_all();
    for (int j = 0; j < 40; j++) begin
      send_req((j % 2 == 0) ? 34'h1000 + 34'($unsigned($random(seed)) % 32'h1000) : pick_addr(),
               pick_type(), (j % 3 == 0) ? pick_priv() : 2'd3);
    end
    finish_requests();
    test_end();

    test_begin("rlb");
    csr_write(pmp_pkg::CSR_ADDR_MSECCFG, 32'h4);
    csr_read(pmp_pkg::CSR_ADDR_MSECCFG, "mseccfg");
    do_reset();
    // RLB first, then locks stop binding
    csr_write(pmp_pkg::CSR_ADDR_MSECCFG, 32'h4);
    csr_write(pmp_pkg::CSR_ADDR_PMPADDR0, 32'h400);
    csr_write(pmp_pkg::CSR_ADDR_PMPADDR0 + 12'd1, 32'h800);
    csr_write(pmp_pkg::CSR_ADDR_PMPCFG0, 32'h0000_8D00);
    csr_write(pmp_pkg::CSR_ADDR_PMPADDR0, 32'h500);
    csr_write(pmp_pkg::CSR_ADDR_PMPADDR0 + 12'd1, 32'h900);
    csr_write(pmp_pkg::CSR_ADDR_PMPCFG0, 32'h0000_8F00);
    read_all();
    for (int j = 0; j < 20; j++) send_req(pick_addr(), pick_type(), pick_priv());
    finish_requests();
    test_end();

    test_begin("mml and mmwp");
    do_reset();
    csr_write(pmp_pkg::CSR_ADDR_MSECCFG, 32'h4);
    csr_write(pmp_pkg::CSR_ADDR_PMPADDR0, 32'h400);
    csr_write(pmp_pkg::CSR_ADDR_PMPADDR0 + 12'd1, 32'h800);
    csr_write(pmp_pkg::CSR_ADDR_PMPADDR0 + 12'd2, 32'hA00);
    csr_write(pmp_pkg::CSR_ADDR_PMPADDR0 + 12'd3, 32'hBFF);
    csr_write(pmp_pkg::CSR_ADDR_MSECCFG, 32'h7);
    csr_read(pmp_pkg::CSR_ADDR_MSECCFG, "mseccfg");
    // RLB stays set so every random config lands
    for (int g = 0; g < 10; g++) begin
      csr_write(pmp_pkg::CSR_ADDR_PMPCFG0, $random(seed) & 32'h9F9F_9F9F);
      csr_read(pmp_pkg::CSR_ADDR_PMPCFG0, "pmpcfg0");
      for (int j = 0; j < 20; j++) send_req(pick_addr(), pick_type(), pick_priv());
      finish_requests();
    end
    csr_write(pmp_pkg::CSR_ADDR_PMPCFG0, 32'h0);
    csr_write(pmp_pkg::CSR_ADDR_MSECCFG, 32'h0);
    read_all();
    // Nothing matches now, MMWP denies M too
    for (int j = 0; j < 20; j++) send_req(pick_addr(), pick_type(), 2'd3);
    finish_requests();
    test_end();

    $display("checks passed: %0d, mismatches: %0d, other errors: %0d, assertion failures: %0d",
             pass_cnt, mismatch_cnt, other_err_cnt, u_dut.u_assertions.fail_cnt);
    if (error_count() == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== pmp_assertions.sv ====
`timescale 1ns/1ps

module pmp_assertions (
  input logic                  clk,
  input logic                  rst_n_i,
  input logic                  req_valid_i,
  input logic                  rsp_valid_o,
  input pmp_pkg::pmp_cfg_t     cfg_i [pmp_pkg::NUM_REGIONS],
  input pmp_pkg::pmp_mseccfg_t mseccfg_i
);

  // Count of failed assertions
  int unsigned fail_cnt = 0;

  // ------------------------------------------------
  // Response timing
  // ------------------------------------------------

  // One response strobe per request, one cycle later
  a_rsp_follows_req: assert property (@(posedge clk) disable iff (!rst_n_i)
    req_valid_i |=> rsp_valid_o)
    else begin
      $error("rsp_valid_o missing one cycle after a request");
      fail_cnt++;
    end

  a_no_spurious_rsp: assert property (@(posedge clk) disable iff (!rst_n_i)
    !req_valid_i |=> !rsp_valid_o)
    else begin
      $error("rsp_valid_o raised without a request");
      fail_cnt++;
    end

  // Response stays quiet through reset
  a_rsp_idle_in_reset: assert property (@(posedge clk) !rst_n_i |-> !rsp_valid_o)
    else begin
      $error("rsp_valid_o high during reset");
      fail_cnt++;
    end

  // ------------------------------------------------
  // Security state
  // ------------------------------------------------

  // MML is sticky
  a_mml_sticky: assert property (@(posedge clk) disable iff (!rst_n_i)
    mseccfg_i.mml |=> mseccfg_i.mml)
    else begin
      $error("mseccfg.mml cleared after being set");
      fail_cnt++;
    end

  // Locked byte frozen unless RLB is set
  for (genvar i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin : g_lock
    a_cfg_locked: assert property (@(posedge clk) disable iff (!rst_n_i)
      (cfg_i[i].lock && !mseccfg_i.rlb) |=> $stable(cfg_i[i]))
      else begin
        $error("locked pmpcfg byte changed while RLB was clear");
        fail_cnt++;
      end
  end

endmodule

bind pmp_top pmp_assertions u_assertions (
  .clk         (clk),
  .rst_n_i     (rst_n_i),
  .req_valid_i (req_valid_i),
  .rsp_valid_o (rsp_valid_o),
  .cfg_i       (cfg),
  .mseccfg_i   (mseccfg)
);

// ==== pmp_top.sv ====
`timescale 1ns/1ps

module pmp_top (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                          csr_we_i,
  input  logic [11:0]                   csr_addr_i,
  input  logic [31:0]                   csr_wdata_i,
  output logic [31:0]                   csr_rdata_o,
  input  logic                          req_valid_i,
  input  logic [pmp_pkg::ADDR_W-1:0]    req_addr_i,
  input  logic [1:0]                    req_type_i,
  input  logic [1:0]                    priv_lvl_i,
  output logic                          rsp_valid_o,
  output logic                          rsp_err_o
);

  // Register contents shared by controller and checker
  pmp_pkg::pmp_cfg_t             cfg  [pmp_pkg::NUM_REGIONS];
  logic [pmp_pkg::ADDR_W-1:0]    addr [pmp_pkg::NUM_REGIONS];
  pmp_pkg::pmp_mseccfg_t         mseccfg;

  pmp_wr_if wr_if ();

  // Lock rules and readback
  pmp_csr_ctrl u_csr_ctrl (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .csr_we_i    (csr_we_i),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .cfg_i       (cfg),
    .addr_i      (addr),
    .mseccfg_i   (mseccfg),
    .wr          (wr_if.ctrl),
    .csr_rdata_o (csr_rdata_o)
  );

  pmp_regfile u_regfile (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .wr        (wr_if.regs),
    .cfg_o     (cfg),
    .addr_o    (addr),
    .mseccfg_o (mseccfg)
  );

  // Raw request fields become typed here
  pmp_checker u_checker (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .cfg_i       (cfg),
    .addr_i      (addr),
    .mseccfg_i   (mseccfg),
    .req_valid_i (req_valid_i),
    .req_addr_i  (req_addr_i),
    .req_type_i  (pmp_pkg::pmp_acc_e'(req_type_i)),
    .priv_lvl_i  (pmp_pkg::priv_lvl_e'(priv_lvl_i)),
    .rsp_valid_o (rsp_valid_o),
    .rsp_err_o   (rsp_err_o)
  );

endmodule

// ==== pmp_checker.sv ====
`timescale 1ns/1ps

module pmp_checker (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  pmp_pkg::pmp_cfg_t             cfg_i [pmp_pkg::NUM_REGIONS],
  input  logic [pmp_pkg::ADDR_W-1:0]    addr_i [pmp_pkg::NUM_REGIONS],
  input  pmp_pkg::pmp_mseccfg_t         mseccfg_i,
  input  logic                          req_valid_i,
  input  logic [pmp_pkg::ADDR_W-1:0]    req_addr_i,
  input  pmp_pkg::pmp_acc_e             req_type_i,
  input  pmp_pkg::priv_lvl_e            priv_lvl_i,
  output logic                          rsp_valid_o,
  output logic                          rsp_err_o
);

  localparam int unsigned HI = pmp_pkg::ADDR_W - 1;
  localparam int unsigned LO = pmp_pkg::GRAN_LSB;

  logic [HI:0]                     start_addr [pmp_pkg::NUM_REGIONS];
  logic [HI:LO]                    addr_mask  [pmp_pkg::NUM_REGIONS];
  logic [pmp_pkg::NUM_REGIONS-1:0] match_eq;
  logic [pmp_pkg::NUM_REGIONS-1:0] match_gt;
  logic [pmp_pkg::NUM_REGIONS-1:0] match_lt;
  logic [pmp_pkg::NUM_REGIONS-1:0] match;
  logic [pmp_pkg::NUM_REGIONS-1:0] basic_ok;
  logic [pmp_pkg::NUM_REGIONS-1:0] mml_ok;
  logic                            is_m;
  logic                            access_fault;

  assign is_m = (priv_lvl_i == pmp_pkg::PRIV_LVL_M);

  for (genvar r = 0; r < pmp_pkg::NUM_REGIONS; r++) begin : g_region

    // ------------------------------------------------
    // Address matching
    // ------------------------------------------------

    // TOR base is the address of the region below, zero for region 0
    if (r == 0) begin : g_base0
      assign start_addr[r] = (cfg_i[r].mode == pmp_pkg::PMP_MODE_TOR) ? '0 : addr_i[r];
    end else begin : g_base
      assign start_addr[r] = (cfg_i[r].mode == pmp_pkg::PMP_MODE_TOR) ? addr_i[r-1] :
                             addr_i[r];
    end

    // NAPOT size comes from the run of trailing ones
    for (genvar b = LO; b <= HI; b++) begin : g_mask
      if (b == LO) begin : g_lsb
        // Smallest NAPOT is 8 bytes, so this bit never compares
        assign addr_mask[r][b] = (cfg_i[r].mode != pmp_pkg::PMP_MODE_NAPOT);
      end else begin : g_upper
        assign addr_mask[r][b] = (cfg_i[r].mode != pmp_pkg::PMP_MODE_NAPOT) ||
                                 !(&addr_i[r][b-1:LO]);
      end
    end

    assign match_eq[r] = (req_addr_i[HI:LO] & addr_mask[r]) ==
                         (start_addr[r][HI:LO] & addr_mask[r]);
    assign match_gt[r] = req_addr_i[HI:LO] > start_addr[r][HI:LO];
    assign match_lt[r] = req_addr_i[HI:LO] < addr_i[r][HI:LO];

    always_comb begin
      case (cfg_i[r].mode)
        pmp_pkg::PMP_MODE_TOR:   match[r] = (match_eq[r] || match_gt[r]) && match_lt[r];
        pmp_pkg::PMP_MODE_NA4:   match[r] = match_eq[r];
        pmp_pkg::PMP_MODE_NAPOT: match[r] = match_eq[r];
        default:                 match[r] = 1'b0;
      endcase
    end

    // ------------------------------------------------
    // Permissions
    // ------------------------------------------------

    assign basic_ok[r] = ((req_type_i == pmp_pkg::PMP_ACC_EXEC)  && cfg_i[r].exec)  ||
                         ((req_type_i == pmp_pkg::PMP_ACC_WRITE) && cfg_i[r].write) ||
                         ((req_type_i == pmp_pkg::PMP_ACC_READ)  && cfg_i[r].read);

    // MML rules, shared regions use the R=0 W=1 encodings
    always_comb begin
      if (!cfg_i[r].read && cfg_i[r].write) begin
        case ({cfg_i[r].lock, cfg_i[r].exec})
          // RW for M, read only below
          2'b00: mml_ok[r] = (req_type_i == pmp_pkg::PMP_ACC_READ) ||
                             ((req_type_i == pmp_pkg::PMP_ACC_WRITE) && is_m);
          // RW shared by all modes
          2'b01: mml_ok[r] = (req_type_i == pmp_pkg::PMP_ACC_READ) ||
                             (req_type_i == pmp_pkg::PMP_ACC_WRITE);
          // Execute only, shared
          2'b10: mml_ok[r] = (req_type_i == pmp_pkg::PMP_ACC_EXEC);
          // RX for M, execute only below
          default: mml_ok[r] = (req_type_i == pmp_pkg::PMP_ACC_EXEC) ||
                               ((req_type_i == pmp_pkg::PMP_ACC_READ) && is_m);
        endcase
      end else if (cfg_i[r].lock && cfg_i[r].read && cfg_i[r].write && cfg_i[r].exec) begin
        // Locked RWX means read only for everyone
        mml_ok[r] = (req_type_i == pmp_pkg::PMP_ACC_READ);
      end else begin
        // Locked rules bind M only, unlocked ones bind S and U only
        mml_ok[r] = (is_m == cfg_i[r].lock) && basic_ok[r];
      end
    end
  end

  // ------------------------------------------------
  // Priority and result
  // ------------------------------------------------

  // Walk downward so region 0 has the last word
  always_comb begin
    access_fault = mseccfg_i.mmwp || !is_m;
    for (int r = pmp_pkg::NUM_REGIONS - 1; r >= 0; r--) begin
      if (match[r]) begin
        if (mseccfg_i.mml) begin
          access_fault = !mml_ok[r];
        end else if (is_m) begin
          access_fault = cfg_i[r].lock && !basic_ok[r];
        end else begin
          access_fault = !basic_ok[r];
        end
      end
    end
  end

  // One-cycle response, fault only flagged with valid
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
      rsp_err_o   <= 1'b0;
    end else begin
      rsp_valid_o <= req_valid_i;
      rsp_err_o   <= req_valid_i && access_fault;
    end
  end

endmodule

// ==== pmp_regfile.sv ====
`timescale 1ns/1ps

module pmp_regfile (
  input  logic                          clk,
  input  logic                          rst_n_i,
  pmp_wr_if.regs                        wr,
  output pmp_pkg::pmp_cfg_t             cfg_o [pmp_pkg::NUM_REGIONS],
  output logic [pmp_pkg::ADDR_W-1:0]    addr_o [pmp_pkg::NUM_REGIONS],
  output pmp_pkg::pmp_mseccfg_t         mseccfg_o
);

  // Only granule bits are stored
  pmp_pkg::pmp_cfg_t                          cfg_q  [pmp_pkg::NUM_REGIONS];
  logic [pmp_pkg::ADDR_W-1:pmp_pkg::GRAN_LSB] addr_q [pmp_pkg::NUM_REGIONS];
  pmp_pkg::pmp_mseccfg_t                      mseccfg_q;

  // ------------------------------------------------
  // Per-region storage
  // ------------------------------------------------

  for (genvar i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin : g_region
    always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
        cfg_q[i]  <= '0;
        addr_q[i] <= '0;
      end else begin
        // Byte i of pmpcfg0 belongs to region i
        if (wr.cfg_we[i]) begin
          cfg_q[i] <= wr.wdata.cfg[i];
        end
        if (wr.addr_we[i]) begin
          addr_q[i] <= wr.wdata;
        end
      end
    end

    assign cfg_o[i]  = cfg_q[i];
    // Low byte bits are never stored
    assign addr_o[i] = {addr_q[i], {pmp_pkg::GRAN_LSB{1'b0}}};
  end

  // ------------------------------------------------
  // Security bits
  // ------------------------------------------------

  // Sticky and RLB rules are already merged by the controller
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mseccfg_q <= '0;
    end else if (wr.mseccfg_we) begin
      mseccfg_q <= wr.mseccfg_next;
    end
  end

  assign mseccfg_o = mseccfg_q;

endmodule

// ==== pmp_csr_ctrl.sv ====
`timescale 1ns/1ps

module pmp_csr_ctrl (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                          csr_we_i,
  input  logic [11:0]                   csr_addr_i,
  input  logic [31:0]                   csr_wdata_i,
  input  pmp_pkg::pmp_cfg_t             cfg_i [pmp_pkg::NUM_REGIONS],
  input  logic [pmp_pkg::ADDR_W-1:0]    addr_i [pmp_pkg::NUM_REGIONS],
  input  pmp_pkg::pmp_mseccfg_t         mseccfg_i,
  pmp_wr_if.ctrl                        wr,
  output logic [31:0]                   csr_rdata_o
);

  logic                            wr_ready_q;
  logic                            wr_en;
  logic                            sel_cfg;
  logic                            sel_msec;
  logic [pmp_pkg::NUM_REGIONS-1:0] sel_addr;
  logic [pmp_pkg::NUM_REGIONS-1:0] cfg_locked;
  logic [pmp_pkg::NUM_REGIONS-1:0] tor_locked;
  logic [pmp_pkg::NUM_REGIONS-1:0] cfg_we;
  logic [pmp_pkg::NUM_REGIONS-1:0] addr_we;
  logic                            any_lock;
  pmp_pkg::pmp_csr_wdata_u         wdata;
  pmp_pkg::pmp_mseccfg_t           msec_wr;
  pmp_pkg::pmp_mseccfg_t           msec_next;

  // Writes are held off until the first edge after reset release
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ready_q <= 1'b0;
    end else begin
      wr_ready_q <= 1'b1;
    end
  end

  assign wr_en = csr_we_i && wr_ready_q;
  assign wdata = csr_wdata_i;

  // CSR number decode
  assign sel_cfg  = (csr_addr_i == pmp_pkg::CSR_ADDR_PMPCFG0);
  assign sel_msec = (csr_addr_i == pmp_pkg::CSR_ADDR_MSECCFG);

  // ------------------------------------------------
  // Lock state and write enables
  // ------------------------------------------------

  always_comb begin
    any_lock = 1'b0;
    for (int i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin
      sel_addr[i]   = (csr_addr_i == pmp_pkg::CSR_ADDR_PMPADDR0 + 12'(i));
      // RLB set bypasses every lock
      cfg_locked[i] = cfg_i[i].lock && !mseccfg_i.rlb;
      any_lock      = any_lock || cfg_i[i].lock;
    end
    for (int i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin
      // A locked TOR region above also freezes this address as its base
      if (i < pmp_pkg::NUM_REGIONS - 1) begin
        tor_locked[i] = cfg_locked[i+1] && (cfg_i[i+1].mode == pmp_pkg::PMP_MODE_TOR);
      end else begin
        tor_locked[i] = 1'b0;
      end
      cfg_we[i]  = wr_en && sel_cfg && !cfg_locked[i];
      addr_we[i] = wr_en && sel_addr[i] && !cfg_locked[i] && !tor_locked[i];
    end
  end

  // MML and MMWP only ever get set
  // RLB only moves while already set or with no lock anywhere
  always_comb begin
    msec_wr        = wdata.msec.sec;
    msec_next.mml  = mseccfg_i.mml  || msec_wr.mml;
    msec_next.mmwp = mseccfg_i.mmwp || msec_wr.mmwp;
    msec_next.rlb  = (mseccfg_i.rlb || !any_lock) ? msec_wr.rlb : mseccfg_i.rlb;
  end

  assign wr.cfg_we       = cfg_we;
  assign wr.addr_we      = addr_we;
  assign wr.mseccfg_we   = wr_en && sel_msec;
  assign wr.wdata        = wdata;
  assign wr.mseccfg_next = msec_next;

  // ------------------------------------------------
  // Readback
  // ------------------------------------------------

  always_comb begin
    csr_rdata_o = '0;
    if (sel_cfg) begin
      for (int i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin
        csr_rdata_o[8*i +: 8] = cfg_i[i];
      end
    end
    if (sel_msec) begin
      csr_rdata_o = {29'b0, mseccfg_i};
    end
    // pmpaddr holds byte address bits 33 to 2
    for (int i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin
      if (sel_addr[i]) begin
        csr_rdata_o = addr_i[i][pmp_pkg::ADDR_W-1:pmp_pkg::GRAN_LSB];
      end
    end
  end

endmodule

// ==== pmp_wr_if.sv ====
`timescale 1ns/1ps

interface pmp_wr_if;

  // Per-region strobes, bit i for region i
  logic [pmp_pkg::NUM_REGIONS-1:0] cfg_we;
  logic [pmp_pkg::NUM_REGIONS-1:0] addr_we;
  logic                            mseccfg_we;

  // Raw write data and the merged security bits
  pmp_pkg::pmp_csr_wdata_u         wdata;
  pmp_pkg::pmp_mseccfg_t           mseccfg_next;

  // Write side, lock rules already applied
  modport ctrl (output cfg_we, addr_we, mseccfg_we, wdata, mseccfg_next);

  // Storage side
  modport regs (input cfg_we, addr_we, mseccfg_we, wdata, mseccfg_next);

endinterface

// ==== pmp_pkg.sv ====
package pmp_pkg;

  // ------------------------------------------------
  // Sizes
  // ------------------------------------------------

  // Implemented regions
  localparam int unsigned NUM_REGIONS = 32'd4;

  // Physical address width in bits
  localparam int unsigned ADDR_W = 34;

  // Low address bits covered by one 4-byte granule
  localparam int unsigned GRAN_LSB = 2;

  // ------------------------------------------------
  // CSR numbers
  // ------------------------------------------------

  localparam logic [11:0] CSR_ADDR_PMPCFG0  = 12'h3A0;
  // pmpaddr1 to pmpaddr3 follow on consecutive numbers
  localparam logic [11:0] CSR_ADDR_PMPADDR0 = 12'h3B0;
  localparam logic [11:0] CSR_ADDR_MSECCFG  = 12'h747;

  // ------------------------------------------------
  // Encodings
  // ------------------------------------------------

  // Address matching mode of one region
  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'd0,
    PMP_MODE_TOR   = 2'd1,
    PMP_MODE_NA4   = 2'd2,
    PMP_MODE_NAPOT = 2'd3
  } pmp_mode_e;

  // Access type of a request
  typedef enum logic [1:0] {
    PMP_ACC_EXEC  = 2'd0,
    PMP_ACC_WRITE = 2'd1,
    PMP_ACC_READ  = 2'd2
  } pmp_acc_e;

  // Privilege level of the hart, 2 is reserved
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'd0,
    PRIV_LVL_S = 2'd1,
    PRIV_LVL_M = 2'd3
  } priv_lvl_e;

  // One pmpcfg byte, bit 7 is L and bit 0 is R
  typedef struct packed {
    logic      lock;
    logic [1:0] reserved;
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  // Smepmp security bits, MML in bit 0
  typedef struct packed {
    logic rlb;
    logic mmwp;
    logic mml;
  } pmp_mseccfg_t;

  // CSR write data seen either as four cfg bytes or as mseccfg
  // Region 0 sits in the low byte
  typedef union packed {
    pmp_cfg_t [NUM_REGIONS-1:0] cfg;
    struct packed {
      logic [28:0]  zero;
      pmp_mseccfg_t sec;
    } msec;
  } pmp_csr_wdata_u;

endpackage
